//--- source/atom_macros.svh
`ifndef ATOM_MACROS_SVH
`define ATOM_MACROS_SVH

//////////////////////////////
// Widths and reset values
//////////////////////////////

// Data and address width
`define ATOM_XLEN       32
// Architectural register count, x0 included
`define ATOM_REG_COUNT  32
// Fetch address out of reset
`define ATOM_RESET_PC   32'h0000_0000

//////////////////////////////
// Major opcodes
//////////////////////////////

`define ATOM_OPC_LUI     7'b0110111
`define ATOM_OPC_AUIPC   7'b0010111
`define ATOM_OPC_JAL     7'b1101111
`define ATOM_OPC_JALR    7'b1100111
`define ATOM_OPC_BRANCH  7'b1100011
`define ATOM_OPC_OPIMM   7'b0010011
`define ATOM_OPC_OP      7'b0110011
// Not executed yet, only its S immediate is formed
`define ATOM_OPC_STORE   7'b0100011

//////////////////////////////
// funct3 codes
//////////////////////////////

// Conditional branches
`define ATOM_F3_BEQ   3'b000
`define ATOM_F3_BNE   3'b001
`define ATOM_F3_BLT   3'b100
`define ATOM_F3_BGE   3'b101
`define ATOM_F3_BLTU  3'b110
`define ATOM_F3_BGEU  3'b111

// ALU group, shared by OP and OP-IMM
`define ATOM_F3_ADD   3'b000
`define ATOM_F3_SLL   3'b001
`define ATOM_F3_SLT   3'b010
`define ATOM_F3_SLTU  3'b011
`define ATOM_F3_XOR   3'b100
`define ATOM_F3_SR    3'b101
`define ATOM_F3_OR    3'b110
`define ATOM_F3_AND   3'b111

// JALR has a single legal funct3
`define ATOM_F3_JALR  3'b000

// funct7 patterns
`define ATOM_F7_BASE  7'b0000000
`define ATOM_F7_ALT   7'b0100000

`endif

//--- source/atom_pkg.sv
`default_nettype none

`include "atom_macros.svh"

package atom_pkg;

    //////////////////////////////
    // Width types
    //////////////////////////////

    // Data word or raw instruction
    typedef logic [`ATOM_XLEN-1:0] word_t;
    // Program counter
    typedef logic [`ATOM_XLEN-1:0] addr_t;
    // Register index, x0 to x31
    typedef logic [4:0]            reg_idx_t;

    //////////////////////////////
    // Control encodings
    //////////////////////////////

    // ALU function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LINK
    } wb_sel_e;

    // Decoded control bundle, one per instruction
    typedef struct packed {
        logic       rf_we;
        wb_sel_e    wb_sel;
        logic       a_is_pc;     // Operand A from PC instead of rs1
        logic       b_is_imm;    // Operand B from immediate instead of rs2
        alu_op_e    alu_op;
        logic       is_branch;
        logic [2:0] branch_f3;   // Condition, only meaningful with is_branch
        logic       is_jal;
        logic       is_jalr;
        logic       illegal;
    } ctrl_t;

    // One record per committed instruction
    typedef struct packed {
        logic     valid;
        logic     illegal;
        addr_t    pc;
        logic     rd_we;
        reg_idx_t rd;
        word_t    rd_data;
    } retire_t;

endpackage

`default_nettype wire

//--- source/atom_decoder.sv
`default_nettype none

`include "atom_macros.svh"

module atom_decoder (
    input  wire atom_pkg::word_t instr_i,
    output atom_pkg::ctrl_t      ctrl_o
);

    //////////////////////////////
    // Instruction fields
    //////////////////////////////

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // funct3 to base ALU op, shifts default to logical
    function automatic atom_pkg::alu_op_e base_alu_op(input logic [2:0] f3);
        case (f3)
            `ATOM_F3_ADD:  base_alu_op = atom_pkg::ALU_ADD;
            `ATOM_F3_SLL:  base_alu_op = atom_pkg::ALU_SLL;
            `ATOM_F3_SLT:  base_alu_op = atom_pkg::ALU_SLT;
            `ATOM_F3_SLTU: base_alu_op = atom_pkg::ALU_SLTU;
            `ATOM_F3_XOR:  base_alu_op = atom_pkg::ALU_XOR;
            `ATOM_F3_SR:   base_alu_op = atom_pkg::ALU_SRL;
            `ATOM_F3_OR:   base_alu_op = atom_pkg::ALU_OR;
            default:       base_alu_op = atom_pkg::ALU_AND;
        endcase
    endfunction

    //////////////////////////////
    // Control table
    //////////////////////////////

    always_comb begin
        // Safe defaults, no side effects
        ctrl_o           = '0;
        ctrl_o.wb_sel    = atom_pkg::WB_ALU;
        ctrl_o.alu_op    = atom_pkg::ALU_ADD;
        ctrl_o.branch_f3 = funct3;

        case (opcode)
            `ATOM_OPC_LUI: begin
                // Immediate straight through the ALU
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.alu_op   = atom_pkg::ALU_PASS_B;
            end
            `ATOM_OPC_AUIPC: begin
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.a_is_pc  = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
            end
            `ATOM_OPC_JAL: begin
                ctrl_o.rf_we  = 1'b1;
                ctrl_o.wb_sel = atom_pkg::WB_LINK;
                ctrl_o.is_jal = 1'b1;
            end
            `ATOM_OPC_JALR: begin
                ctrl_o.rf_we   = 1'b1;
                ctrl_o.wb_sel  = atom_pkg::WB_LINK;
                ctrl_o.is_jalr = 1'b1;
                ctrl_o.illegal = (funct3 != `ATOM_F3_JALR);
            end
            `ATOM_OPC_BRANCH: begin
                // 010 and 011 are unassigned branch codes
                ctrl_o.is_branch = 1'b1;
                ctrl_o.illegal   = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            `ATOM_OPC_OPIMM: begin
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.alu_op   = base_alu_op(funct3);
                // Shift immediates carry funct7 in the upper imm bits
                if (funct3 == `ATOM_F3_SLL) begin
                    ctrl_o.illegal = (funct7 != `ATOM_F7_BASE);
                end else if (funct3 == `ATOM_F3_SR) begin
                    if (funct7 == `ATOM_F7_ALT) begin
                        ctrl_o.alu_op = atom_pkg::ALU_SRA;
                    end else begin
                        ctrl_o.illegal = (funct7 != `ATOM_F7_BASE);
                    end
                end
            end
            `ATOM_OPC_OP: begin
                ctrl_o.rf_we  = 1'b1;
                ctrl_o.alu_op = base_alu_op(funct3);
                if (funct7 == `ATOM_F7_ALT) begin
                    // Only ADD and SR have an alternate form
                    if (funct3 == `ATOM_F3_ADD) begin
                        ctrl_o.alu_op = atom_pkg::ALU_SUB;
                    end else if (funct3 == `ATOM_F3_SR) begin
                        ctrl_o.alu_op = atom_pkg::ALU_SRA;
                    end else begin
                        ctrl_o.illegal = 1'b1;
                    end
                end else begin
                    ctrl_o.illegal = (funct7 != `ATOM_F7_BASE);
                end
            end
            default: begin
                // Loads, stores, system and anything unknown
                ctrl_o.illegal = 1'b1;
            end
        endcase

        // Illegal words must not write or redirect
        if (ctrl_o.illegal) begin
            ctrl_o.rf_we     = 1'b0;
            ctrl_o.wb_sel    = atom_pkg::WB_ALU;
            ctrl_o.is_branch = 1'b0;
            ctrl_o.is_jal    = 1'b0;
            ctrl_o.is_jalr   = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/atom_imm_gen.sv
`default_nettype none

`include "atom_macros.svh"

module atom_imm_gen (
    input  wire atom_pkg::word_t instr_i,
    output atom_pkg::word_t      imm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       sign;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    // Sign bit sits at 31 in every format
    assign sign   = instr_i[31];

    //////////////////////////////
    // Format select and extend
    //////////////////////////////

    always_comb begin
        case (opcode)
            `ATOM_OPC_OPIMM: begin
                if ((funct3 == `ATOM_F3_SLL) || (funct3 == `ATOM_F3_SR)) begin
                    // Shift amount only, funct7 bits dropped
                    imm_o = {27'b0, instr_i[24:20]};
                end else begin
                    imm_o = {{21{sign}}, instr_i[30:20]};
                end
            end
            // I format
            `ATOM_OPC_JALR:
                imm_o = {{21{sign}}, instr_i[30:20]};
            // S format, for future store support
            `ATOM_OPC_STORE:
                imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
            // B format, bit 0 implied zero
            `ATOM_OPC_BRANCH:
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            // U format, low 12 bits zero
            `ATOM_OPC_LUI,
            `ATOM_OPC_AUIPC:
                imm_o = {instr_i[31:12], 12'b0};
            // J format
            `ATOM_OPC_JAL:
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/atom_regfile.sv
`default_nettype none

`include "atom_macros.svh"

module atom_regfile (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire atom_pkg::reg_idx_t rs1_idx_i,
    input  wire atom_pkg::reg_idx_t rs2_idx_i,
    output atom_pkg::word_t         rs1_data_o,
    output atom_pkg::word_t         rs2_data_o,
    input  wire                     we_i,
    input  wire atom_pkg::reg_idx_t rd_idx_i,
    input  wire atom_pkg::word_t    rd_data_i
);

    // Full array, x0 entry cleared by reset and never written
    atom_pkg::word_t regs_q [0:`ATOM_REG_COUNT-1];

    // Write port
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ATOM_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_idx_i != '0)) begin
            regs_q[rd_idx_i] <= rd_data_i;
        end
    end

    // Read ports, combinational
    assign rs1_data_o = regs_q[rs1_idx_i];
    assign rs2_data_o = regs_q[rs2_idx_i];

    //////////////////////////////
    // Checks
    //////////////////////////////

    // x0 reads zero on both ports, whatever was aimed at it
    a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ((rs1_idx_i != '0) || (rs1_data_o == '0)) &&
        ((rs2_idx_i != '0) || (rs2_data_o == '0)));

endmodule

`default_nettype wire

//--- source/atom_exec.sv
`default_nettype none

`include "atom_macros.svh"

module atom_exec (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire atom_pkg::ctrl_t    ctrl_i,
    input  wire atom_pkg::word_t    imm_i,
    input  wire atom_pkg::word_t    rs1_data_i,
    input  wire atom_pkg::word_t    rs2_data_i,
    input  wire atom_pkg::reg_idx_t rd_idx_i,
    output logic                    rf_we_o,
    output atom_pkg::word_t         rf_wdata_o,
    output atom_pkg::addr_t         pc_o,
    output atom_pkg::retire_t       retire_o
);

    atom_pkg::addr_t pc_q;
    atom_pkg::addr_t pc_next;
    atom_pkg::addr_t pc_plus4;
    atom_pkg::addr_t pc_rel;     // pc + imm, JAL and branches
    atom_pkg::addr_t rs1_rel;    // rs1 + imm, JALR
    atom_pkg::word_t op_a;
    atom_pkg::word_t op_b;
    atom_pkg::word_t alu_res;
    logic            cmp_eq;
    logic            cmp_lt;
    logic            cmp_ltu;
    logic            br_cond;
    logic            br_taken;

    //////////////////////////////
    // Operands and ALU
    //////////////////////////////

    assign op_a = ctrl_i.a_is_pc  ? pc_q  : rs1_data_i;
    assign op_b = ctrl_i.b_is_imm ? imm_i : rs2_data_i;

    always_comb begin
        case (ctrl_i.alu_op)
            atom_pkg::ALU_ADD:    alu_res = op_a + op_b;
            atom_pkg::ALU_SUB:    alu_res = op_a - op_b;
            // Shifts use the low five bits only
            atom_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
            atom_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
            atom_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            atom_pkg::ALU_SLT:
                alu_res = {{(`ATOM_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            atom_pkg::ALU_SLTU:
                alu_res = {{(`ATOM_XLEN-1){1'b0}}, (op_a < op_b)};
            atom_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            atom_pkg::ALU_OR:     alu_res = op_a | op_b;
            atom_pkg::ALU_AND:    alu_res = op_a & op_b;
            atom_pkg::ALU_PASS_B: alu_res = op_b;
            default:              alu_res = '0;
        endcase
    end

    //////////////////////////////
    // Branch condition
    //////////////////////////////

    // Always rs1 against rs2, independent of operand muxes
    assign cmp_eq  = (rs1_data_i == rs2_data_i);
    assign cmp_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign cmp_ltu = (rs1_data_i < rs2_data_i);

    always_comb begin
        case (ctrl_i.branch_f3)
            `ATOM_F3_BEQ:  br_cond = cmp_eq;
            `ATOM_F3_BNE:  br_cond = !cmp_eq;
            `ATOM_F3_BLT:  br_cond = cmp_lt;
            `ATOM_F3_BGE:  br_cond = !cmp_lt;
            `ATOM_F3_BLTU: br_cond = cmp_ltu;
            `ATOM_F3_BGEU: br_cond = !cmp_ltu;
            default:       br_cond = 1'b0;
        endcase
    end

    assign br_taken = ctrl_i.is_branch && br_cond;

    //////////////////////////////
    // Next PC
    //////////////////////////////

    assign pc_plus4 = pc_q + 32'd4;
    // Targets forced to word alignment
    assign pc_rel   = (pc_q + imm_i) & ~32'h3;
    assign rs1_rel  = (rs1_data_i + imm_i) & ~32'h3;

    always_comb begin
        if (ctrl_i.is_jalr) begin
            pc_next = rs1_rel;
        end else if (ctrl_i.is_jal || br_taken) begin
            pc_next = pc_rel;
        end else begin
            // Fall-through, illegal words included
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `ATOM_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    //////////////////////////////
    // Write-back and retire
    //////////////////////////////

    assign rf_we_o    = ctrl_i.rf_we;
    assign rf_wdata_o = (ctrl_i.wb_sel == atom_pkg::WB_LINK) ? pc_plus4 : alu_res;

    always_comb begin
        // Every edge out of reset commits the current word
        retire_o.valid   = rst_n_i;
        retire_o.illegal = ctrl_i.illegal;
        retire_o.pc      = pc_q;
        retire_o.rd_we   = rf_we_o;
        retire_o.rd      = rd_idx_i;
        retire_o.rd_data = rf_wdata_o;
    end

    // PC stays word aligned after every commit
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_o.valid |=> (pc_q[1:0] == 2'b00));

    // Decoder flag and write enable agree on illegal words
    a_illegal_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (retire_o.valid && ctrl_i.illegal) |-> (!rf_we_o && (pc_next == pc_plus4)));

endmodule

`default_nettype wire

//--- source/atom_core.sv
`default_nettype none

module atom_core (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  wire atom_pkg::word_t instr_i,
    output atom_pkg::addr_t      imem_addr_o,
    output atom_pkg::retire_t    retire_o
);

    atom_pkg::ctrl_t ctrl;
    atom_pkg::word_t imm;
    atom_pkg::word_t rs1_data;
    atom_pkg::word_t rs2_data;
    logic            rf_we;
    atom_pkg::word_t rf_wdata;

    //////////////////////////////
    // Decode, side by side
    //////////////////////////////

    atom_decoder u_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    atom_imm_gen u_imm_gen (
        .instr_i (instr_i),
        .imm_o   (imm)
    );

    // Register indices come straight from the fetched word
    atom_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_idx_i  (instr_i[19:15]),
        .rs2_idx_i  (instr_i[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_idx_i   (instr_i[11:7]),
        .rd_data_i  (rf_wdata)
    );

    //////////////////////////////
    // Execute and PC
    //////////////////////////////

    atom_exec u_exec (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ctrl_i     (ctrl),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rd_idx_i   (instr_i[11:7]),
        .rf_we_o    (rf_we),
        .rf_wdata_o (rf_wdata),
        .pc_o       (imem_addr_o),
        .retire_o   (retire_o)
    );

endmodule

`default_nettype wire

//--- tb/atom_ref_model.svh
`ifndef ATOM_REF_MODEL_SVH
`define ATOM_REF_MODEL_SVH

// Model state, lives in the including module
logic [31:0]       lfsr_state;
atom_pkg::word_t   m_regs [0:31];
atom_pkg::addr_t   m_pc;
atom_pkg::retire_t exp_ret;
string             cur_test;

//////////////////////////////
// Random source
//////////////////////////////

// Right-shifting Galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit handed out
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
        bits       = {bits[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
endfunction

//////////////////////////////
// Instruction generator
//////////////////////////////

function automatic atom_pkg::word_t random_instr();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [7:0]  step;
    logic [31:0] off;
    logic [31:0] hi;
    logic [6:0]  opc;
    atom_pkg::word_t w;
    kind = 4'(take_bits(4));
    rd   = 5'(take_bits(5));
    rs1  = 5'(take_bits(5));
    rs2  = 5'(take_bits(5));
    f3   = 3'(take_bits(3));
    alt  = 1'(take_bits(1));
    step = 8'(take_bits(8));
    hi   = take_bits(25);
    // Signed word offset, -512 to +508
    off  = {{22{step[7]}}, step, 2'b00};
    case (kind)
        4'd0: begin
            // Roughly one in sixteen lands outside the subset
            case (f3[1:0])
                2'd0:    opc = 7'b0000011;
                2'd1:    opc = `ATOM_OPC_STORE;
                2'd2:    opc = 7'b0001111;
                default: opc = 7'b1110011;
            endcase
            w = {hi[24:0], opc};
        end
        4'd1: w = {hi[19:0], rd, `ATOM_OPC_LUI};
        4'd2: w = {hi[19:0], rd, `ATOM_OPC_AUIPC};
        4'd3: w = {off[20], off[10:1], off[11], off[19:12], rd, `ATOM_OPC_JAL};
        4'd4: w = {off[11:0], rs1, `ATOM_F3_JALR, rd, `ATOM_OPC_JALR};
        4'd5, 4'd6: begin
            // Fold the two unassigned codes onto BLTU and BGEU
            if (f3[2:1] == 2'b01) begin
                f3[2] = 1'b1;
            end
            w = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `ATOM_OPC_BRANCH};
        end
        4'd7, 4'd8, 4'd9, 4'd10, 4'd11: begin
            if (f3 == `ATOM_F3_SLL) begin
                w = {7'b0, rs2, rs1, f3, rd, `ATOM_OPC_OPIMM};
            end else if (f3 == `ATOM_F3_SR) begin
                w = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `ATOM_OPC_OPIMM};
            end else begin
                w = {hi[11:0], rs1, f3, rd, `ATOM_OPC_OPIMM};
            end
        end
        default: begin
            // Alternate form only for SUB and SRA
            w = {1'b0, alt && ((f3 == `ATOM_F3_ADD) || (f3 == `ATOM_F3_SR)), 5'b0,
                 rs2, rs1, f3, rd, `ATOM_OPC_OP};
        end
    endcase
    return w;
endfunction

//////////////////////////////
// Architectural model
//////////////////////////////

function automatic atom_pkg::word_t alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] x, input logic [31:0] y);
    atom_pkg::word_t r;
    case (f3)
        `ATOM_F3_ADD:  r = alt ? (x - y) : (x + y);
        `ATOM_F3_SLL:  r = x << y[4:0];
        `ATOM_F3_SLT:  r = {31'b0, $signed(x) < $signed(y)};
        `ATOM_F3_SLTU: r = {31'b0, x < y};
        `ATOM_F3_XOR:  r = x ^ y;
        `ATOM_F3_SR: begin
            if (alt) begin
                r = $signed(x) >>> y[4:0];
            end else begin
                r = x >> y[4:0];
            end
        end
        `ATOM_F3_OR:   r = x | y;
        default:       r = x & y;
    endcase
    return r;
endfunction

function automatic void reset_model();
    for (int k = 0; k < 32; k++) begin
        m_regs[k] = '0;
    end
    m_pc       = `ATOM_RESET_PC;
    exp_ret    = '0;
    exp_ret.pc = `ATOM_RESET_PC;
    cur_test   = "reset";
endfunction

// Predict the retire record of one word, then commit it
function automatic void step_model(input atom_pkg::word_t instr);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [4:0]      rd;
    atom_pkg::word_t a;
    atom_pkg::word_t b;
    atom_pkg::word_t i_imm;
    atom_pkg::word_t b_imm;
    atom_pkg::word_t u_imm;
    atom_pkg::word_t j_imm;
    atom_pkg::word_t res;
    atom_pkg::addr_t nxt;
    logic            we;
    logic            ill;
    logic            taken;
    opc   = instr[6:0];
    f3    = instr[14:12];
    f7    = instr[31:25];
    rd    = instr[11:7];
    a     = m_regs[instr[19:15]];
    b     = m_regs[instr[24:20]];
    i_imm = {{20{instr[31]}}, instr[31:20]};
    b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    u_imm = {instr[31:12], 12'b0};
    j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    res   = '0;
    nxt   = m_pc + 32'd4;
    we    = 1'b0;
    ill   = 1'b0;
    taken = 1'b0;
    case (opc)
        `ATOM_OPC_LUI: begin
            cur_test = "lui";
            we       = 1'b1;
            res      = u_imm;
        end
        `ATOM_OPC_AUIPC: begin
            cur_test = "auipc";
            we       = 1'b1;
            res      = m_pc + u_imm;
        end
        `ATOM_OPC_JAL: begin
            cur_test = "jal";
            we       = 1'b1;
            res      = m_pc + 32'd4;
            nxt      = (m_pc + j_imm) & ~32'h3;
        end
        `ATOM_OPC_JALR: begin
            cur_test = "jalr";
            ill      = (f3 != `ATOM_F3_JALR);
            we       = 1'b1;
            res      = m_pc + 32'd4;
            if (!ill) begin
                nxt = (a + i_imm) & ~32'h3;
            end
        end
        `ATOM_OPC_BRANCH: begin
            cur_test = "branch";
            case (f3)
                `ATOM_F3_BEQ:  taken = (a == b);
                `ATOM_F3_BNE:  taken = (a != b);
                `ATOM_F3_BLT:  taken = ($signed(a) < $signed(b));
                `ATOM_F3_BGE:  taken = ($signed(a) >= $signed(b));
                `ATOM_F3_BLTU: taken = (a < b);
                `ATOM_F3_BGEU: taken = (a >= b);
                default:       ill = 1'b1;
            endcase
            if (taken) begin
                nxt = (m_pc + b_imm) & ~32'h3;
            end
        end
        `ATOM_OPC_OPIMM: begin
            cur_test = "alu_imm";
            we       = 1'b1;
            ill      = ((f3 == `ATOM_F3_SLL) && (f7 != 7'h00)) ||
                       ((f3 == `ATOM_F3_SR) && (f7 != 7'h00) && (f7 != 7'h20));
            // Bit 30 picks SRAI, ignored by ADDI
            res      = alu_result(f3, (f3 == `ATOM_F3_SR) && instr[30], a, i_imm);
        end
        `ATOM_OPC_OP: begin
            cur_test = "alu_reg";
            we       = 1'b1;
            ill      = !((f7 == 7'h00) ||
                         ((f7 == 7'h20) && ((f3 == `ATOM_F3_ADD) || (f3 == `ATOM_F3_SR))));
            res      = alu_result(f3, instr[30], a, b);
        end
        default: begin
            cur_test = "illegal";
            ill      = 1'b1;
        end
    endcase
    // No write and plain fall-through on illegal words
    if (ill) begin
        we  = 1'b0;
        nxt = m_pc + 32'd4;
    end
    exp_ret.valid   = 1'b1;
    exp_ret.illegal = ill;
    exp_ret.pc      = m_pc;
    exp_ret.rd_we   = we;
    exp_ret.rd      = rd;
    exp_ret.rd_data = res;
    if (we && (rd != 5'd0)) begin
        m_regs[rd] = res;
    end
    m_pc = nxt;
endfunction

`endif

//--- tb/tb_atom_core.sv
`default_nettype none

`include "atom_macros.svh"

module tb_atom_core;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int RUN_CYCLES      = 2000;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + RESET_CYCLES + 100;

    logic               clk_i;
    logic               rst_n_i;
    atom_pkg::word_t    instr_i;
    atom_pkg::addr_t    imem_addr_o;
    atom_pkg::retire_t  retire_o;

    // Program memory, word indexed by fetch address bits 9:2
    atom_pkg::word_t    prog_mem [0:255];

    // Gates the checks until the PC has seen one reset edge
    logic               check_en;
    int                 errors;
    int                 watchdog_ticks;

    `include "atom_ref_model.svh"

    atom_core u_atom_core (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .instr_i     (instr_i),
        .imem_addr_o (imem_addr_o),
        .retire_o    (retire_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //////////////////////////////
    // Retire checks
    //////////////////////////////

    a_reset_idle: assert property (@(posedge clk_i) disable iff (!check_en)
        !rst_n_i |-> (!retire_o.valid && (imem_addr_o == `ATOM_RESET_PC)))
        else begin
            errors++;
            $display("[FAIL] reset_idle: expected valid 0 pc %h, actual valid %b pc %h",
                     `ATOM_RESET_PC, $sampled(retire_o.valid), $sampled(imem_addr_o));
        end

    a_valid: assert property (@(posedge clk_i) disable iff (!check_en)
        rst_n_i |-> (retire_o.valid == exp_ret.valid))
        else begin
            errors++;
            $display("[FAIL] %s valid: expected %b, actual %b", cur_test,
                     exp_ret.valid, $sampled(retire_o.valid));
        end

    // Covers every next-PC choice through the following fetch
    a_pc: assert property (@(posedge clk_i) disable iff (!check_en)
        rst_n_i |-> ((retire_o.pc == exp_ret.pc) && (imem_addr_o == exp_ret.pc)))
        else begin
            errors++;
            $display("[FAIL] %s pc: expected %h, actual %h", cur_test, exp_ret.pc,
                     $sampled(retire_o.pc));
        end

    a_illegal: assert property (@(posedge clk_i) disable iff (!check_en)
        rst_n_i |-> (retire_o.illegal == exp_ret.illegal))
        else begin
            errors++;
            $display("[FAIL] %s illegal: expected %b, actual %b", cur_test,
                     exp_ret.illegal, $sampled(retire_o.illegal));
        end

    a_rd_we: assert property (@(posedge clk_i) disable iff (!check_en)
        rst_n_i |-> (retire_o.rd_we == exp_ret.rd_we))
        else begin
            errors++;
            $display("[FAIL] %s rd_we: expected %b, actual %b", cur_test,
                     exp_ret.rd_we, $sampled(retire_o.rd_we));
        end

    // Index and data only matter on a write, x0 included
    a_rd: assert property (@(posedge clk_i) disable iff (!check_en)
        (rst_n_i && exp_ret.rd_we) |-> (retire_o.rd == exp_ret.rd))
        else begin
            errors++;
            $display("[FAIL] %s rd: expected %0d, actual %0d", cur_test,
                     exp_ret.rd, $sampled(retire_o.rd));
        end

    a_rd_data: assert property (@(posedge clk_i) disable iff (!check_en)
        (rst_n_i && exp_ret.rd_we) |-> (retire_o.rd_data == exp_ret.rd_data))
        else begin
            errors++;
            $display("[FAIL] %s rd_data: expected %h, actual %h", cur_test,
                     exp_ret.rd_data, $sampled(retire_o.rd_data));
        end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        instr_i    = '0;
        check_en   = 1'b0;
        errors     = 0;
        lfsr_state = 32'ha52a_d2e1;
        reset_model();
        for (int k = 0; k < 256; k++) begin
            prog_mem[k] = random_instr();
        end

        // First edge loads the reset PC
        @(posedge clk_i);
        #1 check_en = 1'b1;
        for (int k = 1; k < RESET_CYCLES; k++) begin
            @(posedge clk_i);
        end
        #1 rst_n_i = 1'b1;

        // One instruction per cycle, inputs move 1 unit past the edge
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            instr_i = prog_mem[imem_addr_o[9:2]];
            step_model(prog_mem[m_pc[9:2]]);
            @(posedge clk_i);
            #1;
        end

        $display("Run complete: %0d errors in %0d cycles", errors, RUN_CYCLES);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Run limit
    initial begin
        watchdog_ticks = 0;
        while (watchdog_ticks < WATCHDOG_CYCLES) begin
            #(CLK_PERIOD);
            watchdog_ticks++;
        end
        $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- atom_core.f
+incdir+source
+incdir+tb
source/atom_pkg.sv
source/atom_decoder.sv
source/atom_imm_gen.sv
source/atom_regfile.sv
source/atom_exec.sv
source/atom_core.sv
tb/tb_atom_core.sv
